// ==== fpConstPkg.sv ====
// Format constants for IEEE 754 single precision, imported by the stages that need them
package fpConstPkg;

    // Field widths of the single word
    localparam int EXP_WIDTH = 8;
    localparam int FRAC_WIDTH = 23;

    localparam int EXP_BIAS = 2**(EXP_WIDTH - 1) - 1;

    // All-ones exponent marks infinity or NaN
    localparam logic [EXP_WIDTH-1:0] EXP_SPECIAL = EXP_WIDTH'(2 * EXP_BIAS + 1);

    // Canonical quiet NaN, 7FC00000
    localparam logic [EXP_WIDTH+FRAC_WIDTH:0] QNAN_WORD = {
        1'b0,
        EXP_SPECIAL,
        1'b1,
        {(FRAC_WIDTH - 1){1'b0}}
    };

    // Past this exponent difference every bit of the smaller significand lands in sticky
    localparam int SHIFT_LIMIT = FRAC_WIDTH + 3;

endpackage

// ==== fpTypesPkg.sv ====
// Vector types of the adder datapath, imported by every stage, interface and the top level
package fpTypesPkg;

    import fpConstPkg::*;

    // Packed single word, sign then exponent then fraction
    typedef logic [EXP_WIDTH+FRAC_WIDTH:0] floatWordT;

    // Biased exponent field
    typedef logic [EXP_WIDTH-1:0] exponentT;

    // Stored fraction without the leading bit
    typedef logic [FRAC_WIDTH-1:0] fractionT;

    // Significand with its implicit or explicit leading bit
    typedef logic [FRAC_WIDTH:0] significandT;

    // Raw magnitude sum, one bit wider for the carry
    typedef logic [FRAC_WIDTH+1:0] sumT;

endpackage

// ==== fpbus.sv ====
`timescale 1ns/100ps
// Operand fields and aligned significands passed from capture through alignment to the adder
interface fpbus
    import fpTypesPkg::*;
();

    logic capturedValid;

    // Captured operand fields
    logic signA;
    exponentT exponentA;
    fractionT mantissaA;
    logic signB;
    exponentT exponentB;
    fractionT mantissaB;

    // Alignment results
    significandT alignedMantissaA;
    significandT alignedMantissaB;
    exponentT exponentOut;
    logic guardBit;
    logic roundBit;
    logic stickyBit;

    modport capture (
        output capturedValid, signA, exponentA, mantissaA, signB, exponentB, mantissaB
    );

    modport align (
        input exponentA, mantissaA, exponentB, mantissaB,
        output alignedMantissaA, alignedMantissaB, exponentOut, guardBit, roundBit, stickyBit
    );

    modport adder (
        input capturedValid, signA, signB, alignedMantissaA, alignedMantissaB, exponentOut,
        input guardBit, roundBit, stickyBit
    );

endinterface

// ==== sumBus.sv ====
`timescale 1ns/100ps
// Normalized sum and special-case flags passed from the adder stage to the result packer
interface sumBus
    import fpTypesPkg::*;
();

    logic sumValid;
    logic resultSign;
    exponentT normExponent;
    significandT normSignificand;

    // Bits below the significand, used for rounding
    logic guardBit;
    logic roundBit;
    logic stickyBit;

    logic isNaN;
    logic isInf;
    logic isZero;

    modport adder (
        output sumValid, resultSign, normExponent, normSignificand,
        output guardBit, roundBit, stickyBit, isNaN, isInf, isZero
    );

    modport packer (
        input sumValid, resultSign, normExponent, normSignificand,
        input guardBit, roundBit, stickyBit, isNaN, isInf, isZero
    );

endinterface

// ==== OperandCapture.sv ====
`timescale 1ns/100ps
// Input register stage, loads both operand words on the strobe and splits them into fields
module OperandCapture
    import fpTypesPkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic inValid,
    input  floatWordT operandA,
    input  floatWordT operandB,
    fpbus.capture bus
);

    floatWordT wordA;
    floatWordT wordB;

    // Strobe delayed by one cycle
    always_ff @(posedge clk)
    begin
        if (rst)
            bus.capturedValid <= 1'b0;
        else
            bus.capturedValid <= inValid;
    end

    // Operand words only change when a new pair arrives
    always_ff @(posedge clk)
    begin
        if (inValid)
        begin
            wordA <= operandA;
            wordB <= operandB;
        end
    end

    // Sign, exponent and fraction fields
    assign {bus.signA, bus.exponentA, bus.mantissaA} = wordA;
    assign {bus.signB, bus.exponentB, bus.mantissaB} = wordB;

endmodule

// ==== Alignment.sv ====
`timescale 1ns/100ps
// Exponent compare and right shift of the smaller significand, feeding the adder stage
module Alignment
    import fpTypesPkg::*, fpConstPkg::*;
(
    fpbus.align bus
);

    exponentT exponentDiff;
    logic [FRAC_WIDTH+2:0] extendedA;
    logic [FRAC_WIDTH+2:0] extendedB;

    // Shift right with guard and round in the low two bits, sticky appended below them
    function automatic logic [FRAC_WIDTH+3:0] shiftOut(
        input logic [FRAC_WIDTH+2:0] extended,
        input exponentT distance
    );
        logic [FRAC_WIDTH+2:0] shifted;
        logic [FRAC_WIDTH+2:0] mask;
        logic sticky;
        shifted = extended >> distance;
        mask = ~({(FRAC_WIDTH + 3){1'b1}} << distance);
        if (distance > SHIFT_LIMIT)
            sticky = |extended;
        else
            sticky = |(extended & mask);
        return {shifted, sticky};
    endfunction

    always_comb
    begin
        // Leading one only for normal operands, two spare bits for guard and round
        extendedA = {bus.exponentA != '0, bus.mantissaA, 2'b00};
        extendedB = {bus.exponentB != '0, bus.mantissaB, 2'b00};

        exponentDiff = '0;
        {bus.guardBit, bus.roundBit, bus.stickyBit} = 3'b000;
        bus.alignedMantissaA = extendedA[FRAC_WIDTH+2:2];
        bus.alignedMantissaB = extendedB[FRAC_WIDTH+2:2];
        bus.exponentOut = bus.exponentA;

        if (bus.exponentA == EXP_SPECIAL || bus.exponentB == EXP_SPECIAL)
        begin
            // Infinity or NaN loses its leading one so the adder can tell it apart
            bus.exponentOut = EXP_SPECIAL;
            bus.alignedMantissaA = {bus.exponentA != EXP_SPECIAL, bus.mantissaA};
            bus.alignedMantissaB = {bus.exponentB != EXP_SPECIAL, bus.mantissaB};
        end
        else if (bus.exponentA == '0 && bus.exponentB == '0)
        begin
            // Both zero or subnormal, nothing to shift
            bus.exponentOut = '0;
        end
        else if (bus.exponentA == '0)
        begin
            // Subnormal A sits at an effective exponent of one
            bus.exponentOut = bus.exponentB;
            exponentDiff = bus.exponentB - 1'b1;
            {bus.alignedMantissaA, bus.guardBit, bus.roundBit, bus.stickyBit} =
                shiftOut(extendedA, exponentDiff);
        end
        else if (bus.exponentB == '0)
        begin
            bus.exponentOut = bus.exponentA;
            exponentDiff = bus.exponentA - 1'b1;
            {bus.alignedMantissaB, bus.guardBit, bus.roundBit, bus.stickyBit} =
                shiftOut(extendedB, exponentDiff);
        end
        else if (bus.exponentA > bus.exponentB)
        begin
            bus.exponentOut = bus.exponentA;
            exponentDiff = bus.exponentA - bus.exponentB;
            {bus.alignedMantissaB, bus.guardBit, bus.roundBit, bus.stickyBit} =
                shiftOut(extendedB, exponentDiff);
        end
        else if (bus.exponentB > bus.exponentA)
        begin
            bus.exponentOut = bus.exponentB;
            exponentDiff = bus.exponentB - bus.exponentA;
            {bus.alignedMantissaA, bus.guardBit, bus.roundBit, bus.stickyBit} =
                shiftOut(extendedA, exponentDiff);
        end
        // Equal exponents keep the defaults above
    end

endmodule

// ==== SignificandAdder.sv ====
`timescale 1ns/100ps
// Adds or subtracts the aligned significands, normalizes the sum and flags special results
module SignificandAdder
    import fpTypesPkg::*, fpConstPkg::*;
(
    fpbus.adder align,
    sumBus.adder sum
);

    logic aGreater;
    logic aSpecial;
    logic bSpecial;
    logic found;
    significandT largeSig;
    significandT smallSig;
    exponentT effExponent;
    sumT rawSum;
    logic [2:0] rawLow;
    logic [FRAC_WIDTH+3:0] magnitude;
    logic [FRAC_WIDTH+3:0] normalized;
    logic [4:0] leadZeros;

    assign sum.sumValid = align.capturedValid;

    always_comb
    begin
        // The shifted operand is always the smaller one and owns guard, round and sticky
        aGreater = align.alignedMantissaA >= align.alignedMantissaB;
        largeSig = aGreater ? align.alignedMantissaA : align.alignedMantissaB;
        smallSig = aGreater ? align.alignedMantissaB : align.alignedMantissaA;

        if (align.signA == align.signB)
            {rawSum, rawLow} = {1'b0, largeSig, 3'b000}
                + {1'b0, smallSig, align.guardBit, align.roundBit, align.stickyBit};
        else
            {rawSum, rawLow} = {1'b0, largeSig, 3'b000}
                - {1'b0, smallSig, align.guardBit, align.roundBit, align.stickyBit};

        // Leading one search below the carry bit
        magnitude = {rawSum[FRAC_WIDTH:0], rawLow};
        leadZeros = '0;
        found = 1'b0;
        for (int i = FRAC_WIDTH + 3; i >= 0; i--)
        begin
            if (!found && magnitude[i])
            begin
                found = 1'b1;
                leadZeros = 5'(FRAC_WIDTH + 3 - i);
            end
        end
        normalized = magnitude << leadZeros;

        // Subnormal-only sums still count from exponent one
        effExponent = (align.exponentOut == '0) ? exponentT'(1) : align.exponentOut;

        aSpecial = !align.alignedMantissaA[FRAC_WIDTH];
        bSpecial = !align.alignedMantissaB[FRAC_WIDTH];

        sum.resultSign = aGreater ? align.signA : align.signB;
        sum.normExponent = effExponent - exponentT'(leadZeros);
        {sum.normSignificand, sum.guardBit, sum.roundBit, sum.stickyBit} = normalized;
        sum.isNaN = 1'b0;
        sum.isInf = 1'b0;
        sum.isZero = 1'b0;

        if (align.exponentOut == EXP_SPECIAL)
        begin
            // Nonzero fraction without a leading one is a NaN
            sum.isNaN = (aSpecial && align.alignedMantissaA[FRAC_WIDTH-1:0] != '0)
                || (bSpecial && align.alignedMantissaB[FRAC_WIDTH-1:0] != '0)
                || (aSpecial && bSpecial && align.signA != align.signB);
            sum.isInf = !sum.isNaN;
            sum.resultSign = aSpecial ? align.signA : align.signB;
        end
        else if (rawSum[FRAC_WIDTH+1])
        begin
            // Carry out, one step right
            sum.normExponent = effExponent + 1'b1;
            sum.normSignificand = rawSum[FRAC_WIDTH+1:1];
            sum.guardBit = rawSum[0];
            sum.roundBit = rawLow[2];
            sum.stickyBit = |rawLow[1:0];
        end
        else if (magnitude == '0)
        begin
            // Negative only when both operands are negative zeros
            sum.isZero = 1'b1;
            sum.resultSign = align.signA & align.signB;
        end
        else if (effExponent <= exponentT'(leadZeros))
        begin
            sum.isZero = 1'b1;
        end
    end

endmodule

// ==== ResultPacker.sv ====
`timescale 1ns/100ps
// Rounds to nearest even, packs the result word and registers it with the output pulse
module ResultPacker
    import fpTypesPkg::*, fpConstPkg::*;
(
    input  logic clk,
    input  logic rst,
    sumBus.packer sum,
    output logic outValid,
    output floatWordT result
);

    logic roundUp;
    sumT roundedSig;
    logic [EXP_WIDTH:0] finalExp;
    fractionT finalFrac;
    floatWordT nextWord;

    always_comb
    begin
        // Ties go to the even significand
        roundUp = sum.guardBit & (sum.roundBit | sum.stickyBit | sum.normSignificand[0]);
        roundedSig = {1'b0, sum.normSignificand} + sumT'(roundUp);

        // Rounding carry renormalizes by one place
        finalExp = {1'b0, sum.normExponent} + roundedSig[FRAC_WIDTH+1];
        if (roundedSig[FRAC_WIDTH+1])
            finalFrac = roundedSig[FRAC_WIDTH:1];
        else
            finalFrac = roundedSig[FRAC_WIDTH-1:0];

        if (sum.isNaN)
            nextWord = QNAN_WORD;
        else if (sum.isInf)
            nextWord = {sum.resultSign, EXP_SPECIAL, fractionT'(0)};
        else if (sum.isZero)
            nextWord = {sum.resultSign, exponentT'(0), fractionT'(0)};
        else if (finalExp >= EXP_SPECIAL)
            // Overflow saturates to infinity
            nextWord = {sum.resultSign, EXP_SPECIAL, fractionT'(0)};
        else
            nextWord = {sum.resultSign, finalExp[EXP_WIDTH-1:0], finalFrac};
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            outValid <= 1'b0;
            result <= '0;
        end
        else
        begin
            outValid <= sum.sumValid;
            // Result holds until the next valid sum
            if (sum.sumValid)
                result <= nextWord;
        end
    end

endmodule

// ==== FpAdder.sv ====
`timescale 1ns/100ps
// Top level of the single precision adder, result appears two clocks after the input strobe
module FpAdder
    import fpTypesPkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic inValid,
    input  floatWordT operandA,
    input  floatWordT operandB,
    output logic outValid,
    output floatWordT result
);

    fpbus operandBus();
    sumBus resultBus();

    OperandCapture OperandCapture_inst (
        .clk(clk),
        .rst(rst),
        .inValid(inValid),
        .operandA(operandA),
        .operandB(operandB),
        .bus(operandBus.capture)
    );

    Alignment Alignment_inst (
        .bus(operandBus.align)
    );

    SignificandAdder SignificandAdder_inst (
        .align(operandBus.adder),
        .sum(resultBus.adder)
    );

    ResultPacker ResultPacker_inst (
        .clk(clk),
        .rst(rst),
        .sum(resultBus.packer),
        .outValid(outValid),
        .result(result)
    );

endmodule

// ==== tbFpAdder_sva.sv ====
`timescale 1ns/100ps
// Assertions on output pulse timing and reset behavior, bound into the adder top level
module fpAdderChecks
    import fpTypesPkg::*;
(
    input logic clk,
    input logic rst,
    input logic inValid,
    input logic outValid,
    input floatWordT result
);

    // Fixed two cycle latency seen from both ends
    validToOut: assert property (@(posedge clk) disable iff (rst) inValid |-> ##2 outValid)
        else $error("outValid did not follow inValid after two cycles");

    outFromValid: assert property (@(posedge clk) disable iff (rst) outValid |-> $past(inValid, 2))
        else $error("outValid raised without inValid two cycles earlier");

    // Quiet output while in reset and on the cycle that follows
    quietInReset: assert property (@(posedge clk) rst |-> ##1 !outValid ##1 !outValid)
        else $error("outValid high during or right after reset");

    knownResult: assert property (@(posedge clk) outValid |-> !$isunknown(result))
        else $error("result holds unknown bits while outValid is high");

endmodule

bind FpAdder fpAdderChecks fpAdderChecks_inst (
    .clk(clk),
    .rst(rst),
    .inValid(inValid),
    .outValid(outValid),
    .result(result)
);

// ==== tbFpAdder.sv ====
`timescale 1ns/100ps
// Testbench for the adder, replays the hex patterns in a burst and one at a time and checks each sum
module tbFpAdder
    import fpTypesPkg::*;
();

    localparam int TEST_COUNT = 25;
    localparam int LATENCY = 2;
    localparam int TIMEOUT_CYCLES = 2 * TEST_COUNT * 4 + 50;

    logic clk;
    logic rst;
    logic inValid;
    floatWordT operandA;
    floatWordT operandB;
    logic outValid;
    floatWordT result;

    // Each test holds A, B and the expected sum in three words
    floatWordT patternMem [0:3*TEST_COUNT-1];

    // Pairs in flight with the oldest first
    floatWordT expectQ[$];
    int issueQ[$];
    string nameQ[$];

    int cycleCount;
    int doneCount;
    int failCount;
    int strayCount;

    FpAdder FpAdder_inst (
        .clk(clk),
        .rst(rst),
        .inValid(inValid),
        .operandA(operandA),
        .operandB(operandB),
        .outValid(outValid),
        .result(result)
    );

    always #4 clk = ~clk;

    always @(posedge clk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES)
        begin
            $display("Timeout after %0d cycles, %0d results never arrived", cycleCount,
                expectQ.size());
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic checkResult(input string name, input floatWordT expected,
        input floatWordT actual, output bit ok);
        ok = (actual === expected);
        if (!ok)
            $display("** Error: %s expected %h actual %h", name, expected, actual);
    endtask

    task automatic checkLatency(input string name, input int expected, input int actual,
        output bit ok);
        ok = (actual == expected);
        if (!ok)
            $display("** Error: %s latency expected %0d actual %0d", name, expected, actual);
    endtask

    // Operand pair is driven on the falling edge and sampled by the next rising edge
    task sendPair(input int index, input string passName);
        @(negedge clk);
        operandA = patternMem[3 * index];
        operandB = patternMem[3 * index + 1];
        inValid = 1'b1;
        expectQ.push_back(patternMem[3 * index + 2]);
        // Latency counts from the cycle in which the pair is presented
        issueQ.push_back(cycleCount);
        nameQ.push_back($sformatf("%s[%0d]", passName, index));
    endtask

    task holdIdle(input int cycles);
        repeat (cycles)
        begin
            @(negedge clk);
            inValid = 1'b0;
        end
    endtask

    // Outputs are registered, so the falling edge sees them settled
    always @(negedge clk)
    begin : monitor
        bit valueOk;
        bit timingOk;
        string name;
        floatWordT expected;
        int issued;
        if (!rst && outValid)
        begin
            if (expectQ.size() == 0)
            begin
                $display("Unexpected outValid at cycle %0d with no operand pair in flight",
                    cycleCount);
                strayCount++;
            end
            else
            begin
                name = nameQ.pop_front();
                expected = expectQ.pop_front();
                issued = issueQ.pop_front();
                checkResult(name, expected, result, valueOk);
                checkLatency(name, LATENCY, cycleCount - issued, timingOk);
                doneCount++;
                if (valueOk && timingOk)
                    $display("%s result %h pass", name, result);
                else
                begin
                    failCount++;
                    $display("%s result %h fail", name, result);
                end
            end
        end
    end

    initial
    begin
        clk = 1'b0;
        rst = 1'b1;
        inValid = 1'b0;
        operandA = '0;
        operandB = '0;
        cycleCount = 0;
        doneCount = 0;
        failCount = 0;
        strayCount = 0;
        $readmemh("fpAddPatterns.hex", patternMem);

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Back to back with one pair per cycle
        for (int i = 0; i < TEST_COUNT; i++)
            sendPair(i, "burst");
        holdIdle(4);

        // Each pair alone with idle cycles around it
        for (int i = 0; i < TEST_COUNT; i++)
        begin
            sendPair(i, "single");
            holdIdle(3);
        end

        while (expectQ.size() != 0)
            @(negedge clk);
        holdIdle(4);
        @(posedge clk);

        $display("Summary: %0d tests, %0d passed, %0d failed, %0d unexpected outputs",
            doneCount, doneCount - failCount, failCount, strayCount);
        if (failCount == 0 && strayCount == 0 && doneCount == 2 * TEST_COUNT)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== fpAddPatterns.hex ====
// Columns: operand A, operand B, expected sum as IEEE 754 single words in hex
// Nearest even rounding, NaN results canonical, results below the normal range flushed to zero
3F800000 3F800000 40000000 // 1 + 1 carries into the exponent
3F800000 40000000 40400000 // 1 + 2 with a one step shift
3F800000 30800000 3F800000 // Gap of 30 leaves only sticky
3F800000 33800001 3F800001 // Guard plus sticky rounds up
3F800000 BF400000 3E800000 // 1 - 0.75 normalizes left by two
3F800000 C0000000 BF800000 // Larger operand gives the sign
3FC00000 BFC00000 00000000 // Exact cancellation is +0
80000000 80000000 80000000 // Two negative zeros
00800001 80800000 00000000 // Underflow flushes to +0
80800001 00800000 80000000 // Underflow keeps the negative sign
3F800000 33800000 3F800000 // Tie on an even significand stays
3F800001 33800000 3F800002 // Tie on an odd significand rounds up
3FFFFFFF 33800000 40000000 // Rounding carry raises the exponent
3F800000 B3000000 3F800000 // Subtraction then rounding carry
7F7FFFFF 7F7FFFFF 7F800000 // Sum overflows to infinity
7F7FFFFF 73000000 7F800000 // Rounding overflows to infinity
7FC00000 3F800000 7FC00000 // Quiet NaN input
FF800001 3F800000 7FC00000 // Signaling NaN input
7F800000 40400000 7F800000 // Infinity plus finite
3F800000 FF800000 FF800000 // Finite plus negative infinity
7F800000 FF800000 7FC00000 // Opposite infinities
00400000 00800000 00C00000 // Subnormal plus smallest normal
00000001 3F800000 3F800000 // Tiny subnormal only sets sticky
00400000 00400000 00800000 // Two subnormals reach the normal range
00000001 00000001 00000000 // Two subnormals stay tiny and flush

// ==== sources.f ====
fpConstPkg.sv
fpTypesPkg.sv
fpbus.sv
sumBus.sv
OperandCapture.sv
Alignment.sv
SignificandAdder.sv
ResultPacker.sv
FpAdder.sv
tbFpAdder_sva.sv
tbFpAdder.sv

// ==== Makefile ====
TOP = tbFpAdder

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sources.f

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "TEST FAILED" sim.log; then \
		echo "Simulation failed, see sim.log"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
